// ==== vlog.f ====
+incdir+test
rtl/idex_pkg.sv
rtl/inst_decode.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/idex_stage.sv
test/tb_idex.sv

// ==== test/tb_idex_check.svh ====
`ifndef TB_IDEX_CHECK_SVH
`define TB_IDEX_CHECK_SVH

// xlen wide results: write data, next pc
task automatic check_data(input string what, input logic [xlen-1:0] got,
		input logic [xlen-1:0] want);
	if (got !== want) begin
		$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
		$display("TESTBENCH FAILED");
		$fatal(1, "data mismatch");
	end
endtask

// register indices
task automatic check_addr(input string what, input logic [reg_addr_w-1:0] got,
		input logic [reg_addr_w-1:0] want);
	if (got !== want) begin
		$display("error at %0t ns: %s is x%0d, expected x%0d", $time, what, got, want);
		$display("TESTBENCH FAILED");
		$fatal(1, "address mismatch");
	end
endtask

// strobes and flags
task automatic check_flag(input string what, input logic got, input logic want);
	if (got !== want) begin
		$display("error at %0t ns: %s is %b, expected %b", $time, what, got, want);
		$display("TESTBENCH FAILED");
		$fatal(1, "flag mismatch");
	end
endtask

`endif

// ==== test/tb_idex.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_idex import idex_pkg::*; ();

	typedef struct packed {
		logic we;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0] data;
		logic [xlen-1:0] next_pc;
		logic err;
	} expect_t;

	logic clk;
	logic rst;
	logic inst_valid;
	logic [inst_w-1:0] inst;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;
	logic [reg_addr_w-1:0] raddr1;
	logic [reg_addr_w-1:0] raddr2;
	logic result_valid;
	logic reg_we;
	logic [reg_addr_w-1:0] reg_waddr;
	logic [xlen-1:0] reg_wdata;
	logic [xlen-1:0] pc_n;
	logic inst_err;

	logic [xlen-1:0] regs [32];     // register file model
	expect_t exp_q [$];             // results in flight

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	always #2 clk = ~clk;

	idex_stage idex_stage_i (
		.clk_i          (clk),
		.rst_i          (rst),
		.inst_valid_i   (inst_valid),
		.inst_i         (inst),
		.pc_i           (pc),
		.reg_rdata1_i   (rdata1),
		.reg_rdata2_i   (rdata2),
		.reg_raddr1_o   (raddr1),
		.reg_raddr2_o   (raddr2),
		.result_valid_o (result_valid),
		.reg_we_o       (reg_we),
		.reg_waddr_o    (reg_waddr),
		.reg_wdata_o    (reg_wdata),
		.pc_n_o         (pc_n),
		.inst_err_o     (inst_err)
	);

	`include "tb_idex_check.svh"

	function automatic logic [31:0] enc_i(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
			logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], branch};
	endfunction

	function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, jal};
	endfunction

	// rv32i integer semantics
	function automatic logic [xlen-1:0] alu_ref(alu_op_e op, logic [xlen-1:0] a,
			logic [xlen-1:0] b);
		case (op)
			add:     return a + b;
			sub:     return a - b;
			sll:     return a << b[4:0];
			slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			sltu:    return (a < b) ? 32'd1 : 32'd0;
			xor_op:  return a ^ b;
			srl:     return a >> b[4:0];
			sra:     return $signed(a) >>> b[4:0];
			or_op:   return a | b;
			and_op:  return a & b;
			default: return b;
		endcase
	endfunction

	function automatic logic taken_ref(logic [2:0] f3, logic [xlen-1:0] a, logic [xlen-1:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic compare_front();
		expect_t e;
		e = exp_q.pop_front();
		check_flag("reg_we_o", reg_we, e.we);
		check_flag("inst_err_o", inst_err, e.err);
		check_data("pc_n_o", pc_n, e.next_pc);
		if (e.we) begin
			check_addr("reg_waddr_o", reg_waddr, e.rd);
			check_data("reg_wdata_o", reg_wdata, e.data);
		end
	endtask

	// one instruction per falling edge, earlier result due on the same edge
	task automatic send(input logic [inst_w-1:0] word, input logic [xlen-1:0] addr,
			input expect_t e);
		@(negedge clk);
		if (exp_q.size() != 0) begin
			check_flag("result_valid_o", result_valid, 1'b1);
			compare_front();
		end
		inst_valid = 1'b1;
		inst = word;
		pc = addr;
		exp_q.push_back(e);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			inst_valid = 1'b0;
			if (result_valid) begin
				compare_front();
			end else begin
				waited++;
				if (waited > 8) begin
					$display("timed out waiting for result_valid_o");
					$display("TESTBENCH FAILED");
					$fatal(1, "timeout");
				end
			end
		end
		@(negedge clk);     // idle cycle behind the stream
		check_flag("result_valid_o idle", result_valid, 1'b0);
		check_flag("reg_we_o idle", reg_we, 1'b0);
		check_flag("inst_err_o idle", inst_err, 1'b0);
	endtask

	task automatic test_reg_imm();
		alu_op_e ops [9] = '{add, slt, sltu, xor_op, or_op, and_op, sll, srl, sra};
		logic [2:0] f3s [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
		logic [11:0] imm;
		logic [xlen-1:0] addr;
		expect_t e;
		for (int i = 0; i < 9; i++) begin
			regs[7] = $urandom;
			imm = $urandom;
			if (i >= 6) begin
				imm[11:5] = (ops[i] == sra) ? funct7_alt : 7'b0;    // shamt form
			end
			addr = $urandom & 32'hffff_fffc;
			e = '{we: 1'b1, rd: 5'd3, data: alu_ref(ops[i], regs[7], {{20{imm[11]}}, imm}),
				next_pc: addr + 4, err: 1'b0};
			send(enc_i(op_imm, f3s[i], 5'd3, 5'd7, imm), addr, e);
			drain();
		end
	endtask

	task automatic test_reg_reg();
		alu_op_e ops [10] = '{add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op};
		logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		logic [6:0] f7;
		expect_t e;
		regs[8] = $urandom;
		regs[9] = $urandom;
		for (int i = 0; i < 10; i++) begin
			f7 = (ops[i] == sub || ops[i] == sra) ? funct7_alt : 7'b0;
			e = '{we: 1'b1, rd: 5'(i + 10), data: alu_ref(ops[i], regs[8], regs[9]),
				next_pc: 32'h104 + 4 * i, err: 1'b0};
			send(enc_r(f7, f3s[i], 5'(i + 10), 5'd8, 5'd9), 32'h100 + 4 * i, e);
		end
		drain();
	endtask

	task automatic test_upper();
		logic [19:0] imm;
		expect_t e;
		imm = $urandom;
		e = '{we: 1'b1, rd: 5'd4, data: {imm, 12'h0}, next_pc: 32'h2004, err: 1'b0};
		send({imm, 5'd4, lui}, 32'h2000, e);
		e = '{we: 1'b1, rd: 5'd5, data: 32'h2004 + {imm, 12'h0}, next_pc: 32'h2008,
			err: 1'b0};
		send({imm, 5'd5, auipc}, 32'h2004, e);
		drain();
	endtask

	task automatic test_branches();
		logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		logic [12:0] off;
		logic [xlen-1:0] addr;
		logic [4:0] src1;
		logic [4:0] src2;
		expect_t e;
		regs[11] = 32'h1234_5678;   // equal pair
		regs[12] = 32'h1234_5678;
		regs[13] = 32'hffff_fff0;   // negative but large unsigned
		regs[14] = 32'h0000_0010;
		for (int i = 0; i < 18; i++) begin
			off = $urandom & 13'h1ffe;
			addr = 32'h4000 + 4 * i;
			if (i / 6 == 2) begin
				src1 = 5'd14;       // reversed pair
				src2 = 5'd13;
			end else begin
				src1 = 5'(11 + 2 * (i / 6));
				src2 = 5'(12 + 2 * (i / 6));
			end
			e = '{we: 1'b0, rd: 5'd0, data: 32'h0, next_pc: addr + 4, err: 1'b0};
			if (taken_ref(f3s[i % 6], regs[src1], regs[src2])) begin
				e.next_pc = addr + {{19{off[12]}}, off};
			end
			send(enc_b(f3s[i % 6], src1, src2, off), addr, e);
		end
		drain();
	endtask

	task automatic test_jumps();
		logic [20:0] joff;
		logic [11:0] imm;
		expect_t e;
		joff = $urandom & 21'h1ffffe;
		e = '{we: 1'b1, rd: 5'd1, data: 32'h8004, next_pc: 32'h8000 + {{11{joff[20]}}, joff},
			err: 1'b0};
		send(enc_j(5'd1, joff), 32'h8000, e);
		regs[20] = $urandom;
		imm = $urandom;
		e = '{we: 1'b1, rd: 5'd2, data: 32'h9004,
			next_pc: (regs[20] + {{20{imm[11]}}, imm}) & 32'hffff_fffe, err: 1'b0};
		send(enc_i(jalr, 3'd0, 5'd2, 5'd20, imm), 32'h9000, e);
		drain();
	endtask

	task automatic test_illegal();
		expect_t e;
		e = '{we: 1'b0, rd: 5'd0, data: 32'h0, next_pc: 32'hc000, err: 1'b1};
		send(enc_i(7'b0000011, 3'd2, 5'd6, 5'd7, 12'h010), 32'hc000, e);     // lw
		e.next_pc = 32'hc004;
		send(enc_i(7'b0100011, 3'd2, 5'd6, 5'd7, 12'h010), 32'hc004, e);     // sw
		e.next_pc = 32'hc008;
		send(enc_i(system, 3'd1, 5'd6, 5'd7, 12'h300), 32'hc008, e);         // csrrw
		e.next_pc = 32'hc00c;
		send(enc_r(7'b0000001, 3'd0, 5'd6, 5'd7, 5'd8), 32'hc00c, e);        // mul
		drain();
	endtask

	initial begin
		void'($urandom(32'h909fdff9));
		clk = 1'b0;
		rst = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		pc = '0;
		foreach (regs[i]) begin
			regs[i] = $urandom;
		end
		regs[0] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_flag("result_valid_o after reset", result_valid, 1'b0);
		check_flag("reg_we_o after reset", reg_we, 1'b0);
		check_flag("inst_err_o after reset", inst_err, 1'b0);
		test_reg_imm();
		test_reg_reg();
		test_upper();
		test_branches();
		test_jumps();
		test_illegal();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/idex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module idex_stage import idex_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   rst_i,
	input  wire logic                   inst_valid_i,
	input  wire logic [inst_w-1:0]      inst_i,
	input  wire logic [xlen-1:0]        pc_i,
	input  wire logic [xlen-1:0]        reg_rdata1_i,
	input  wire logic [xlen-1:0]        reg_rdata2_i,
	output logic [reg_addr_w-1:0]       reg_raddr1_o,   // rs1 index, same cycle
	output logic [reg_addr_w-1:0]       reg_raddr2_o,   // rs2 index, same cycle
	output logic                        result_valid_o,
	output logic                        reg_we_o,
	output logic [reg_addr_w-1:0]       reg_waddr_o,
	output logic [xlen-1:0]             reg_wdata_o,
	output logic [xlen-1:0]             pc_n_o,
	output logic                        inst_err_o
);

	alu_op_e alu_op;
	flow_e flow;
	logic [xlen-1:0] operand_a;
	logic [xlen-1:0] operand_b;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] next_pc;
	logic [reg_addr_w-1:0] rd;
	logic reg_we;
	logic illegal;

	assign reg_raddr1_o = inst_i[19:15];
	assign reg_raddr2_o = inst_i[24:20];

	inst_decode inst_decode_i (
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.reg_rdata1_i (reg_rdata1_i),
		.reg_rdata2_i (reg_rdata2_i),
		.alu_op_o     (alu_op),
		.operand_a_o  (operand_a),
		.operand_b_o  (operand_b),
		.imm_o        (imm),
		.flow_o       (flow),
		.rd_o         (rd),
		.reg_we_o     (reg_we),
		.illegal_o    (illegal)
	);

	int_alu int_alu_i (
		.alu_op_i    (alu_op),
		.operand_a_i (operand_a),
		.operand_b_i (operand_b),
		.result_o    (alu_result)
	);

	branch_unit branch_unit_i (
		.flow_i     (flow),
		.pc_i       (pc_i),
		.rs1_i      (reg_rdata1_i),
		.rs2_i      (reg_rdata2_i),
		.imm_i      (imm),
		.illegal_i  (illegal),
		.next_pc_o  (next_pc)
	);

	// control flags, one result per strobe
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			result_valid_o <= 1'b0;
			reg_we_o <= 1'b0;
			inst_err_o <= 1'b0;
		end else begin
			result_valid_o <= inst_valid_i;
			reg_we_o <= inst_valid_i & reg_we;
			inst_err_o <= inst_valid_i & illegal;
		end
	end

	// payload holds when no instruction comes in
	always_ff @(posedge clk_i) begin
		if (inst_valid_i) begin
			reg_waddr_o <= rd;
			reg_wdata_o <= alu_result;
			pc_n_o <= next_pc;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_unit import idex_pkg::*; (
	input  flow_e                 flow_i,
	input  wire logic [xlen-1:0]  pc_i,
	input  wire logic [xlen-1:0]  rs1_i,
	input  wire logic [xlen-1:0]  rs2_i,
	input  wire logic [xlen-1:0]  imm_i,
	input  wire logic             illegal_i,
	output logic [xlen-1:0]       next_pc_o
);

	logic eq;
	logic lt_s;
	logic lt_u;
	logic taken;
	logic [xlen-1:0] pc_imm;
	logic [xlen-1:0] pc_seq;
	logic [xlen-1:0] reg_sum;

	assign eq = (rs1_i == rs2_i);
	assign lt_s = $signed(rs1_i) < $signed(rs2_i);
	assign lt_u = rs1_i < rs2_i;

	assign pc_imm = pc_i + imm_i;       // branch and jal target
	assign pc_seq = pc_i + pc_step;
	assign reg_sum = rs1_i + imm_i;     // jalr base + offset

	always_comb begin
		case (flow_i)
			beq:     taken = eq;
			bne:     taken = ~eq;
			blt:     taken = lt_s;
			bge:     taken = ~lt_s;
			bltu:    taken = lt_u;
			bgeu:    taken = ~lt_u;
			jump_pc: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (illegal_i) begin
			next_pc_o = pc_i;       // hold pc on a bad instruction
		end else if (flow_i == jump_reg) begin
			next_pc_o = {reg_sum[xlen-1:1], 1'b0};
		end else if (taken) begin
			next_pc_o = pc_imm;
		end else begin
			next_pc_o = pc_seq;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/int_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module int_alu import idex_pkg::*; (
	input  alu_op_e               alu_op_i,
	input  wire logic [xlen-1:0]  operand_a_i,
	input  wire logic [xlen-1:0]  operand_b_i,
	output logic [xlen-1:0]       result_o
);

	logic sub_en;
	logic [xlen-1:0] b_inv;
	logic [xlen:0] sum;         // carry out on top
	logic [4:0] shift_amt;
	logic lt_s;
	logic lt_u;

	// one adder serves add, sub and both compares
	assign sub_en = (alu_op_i == sub) || (alu_op_i == slt) || (alu_op_i == sltu);
	assign b_inv = operand_b_i ^ {xlen{sub_en}};
	assign sum = {1'b0, operand_a_i} + {1'b0, b_inv} + {{xlen{1'b0}}, sub_en};

	assign lt_u = ~sum[xlen];   // no carry means a < b
	assign lt_s = (operand_a_i[xlen-1] != operand_b_i[xlen-1]) ?
			operand_a_i[xlen-1] : sum[xlen-1];

	assign shift_amt = operand_b_i[4:0];

	always_comb begin
		case (alu_op_i)
			add, sub: begin
				result_o = sum[xlen-1:0];
			end
			sll: begin
				result_o = operand_a_i << shift_amt;
			end
			slt: begin
				result_o = {{(xlen-1){1'b0}}, lt_s};
			end
			sltu: begin
				result_o = {{(xlen-1){1'b0}}, lt_u};
			end
			xor_op: begin
				result_o = operand_a_i ^ operand_b_i;
			end
			srl: begin
				result_o = operand_a_i >> shift_amt;
			end
			sra: begin
				result_o = $unsigned($signed(operand_a_i) >>> shift_amt);
			end
			or_op: begin
				result_o = operand_a_i | operand_b_i;
			end
			and_op: begin
				result_o = operand_a_i & operand_b_i;
			end
			default: begin      // pass_b
				result_o = operand_b_i;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/inst_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_decode import idex_pkg::*; (
	input  wire logic [inst_w-1:0] inst_i,
	input  wire logic [xlen-1:0]   pc_i,
	input  wire logic [xlen-1:0]   reg_rdata1_i,   // rs1 value
	input  wire logic [xlen-1:0]   reg_rdata2_i,   // rs2 value
	output alu_op_e                alu_op_o,
	output logic [xlen-1:0]        operand_a_o,
	output logic [xlen-1:0]        operand_b_o,
	output logic [xlen-1:0]        imm_o,          // offset for the branch unit
	output flow_e                  flow_o,
	output logic [reg_addr_w-1:0]  rd_o,
	output logic                   reg_we_o,
	output logic                   illegal_o
);

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] shamt;
	logic [xlen-1:0] imm_i_type;
	logic [xlen-1:0] imm_b_type;
	logic [xlen-1:0] imm_u_type;
	logic [xlen-1:0] imm_j_type;

	assign opcode = opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign shamt = inst_i[24:20];
	assign rd_o = inst_i[11:7];

	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u_type = {inst_i[31:12], 12'h000};
	assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		alu_op_o = add;
		operand_a_o = reg_rdata1_i;
		operand_b_o = reg_rdata2_i;
		imm_o = imm_i_type;
		flow_o = seq;
		reg_we_o = 1'b0;
		illegal_o = 1'b0;
		case (opcode)
			op_imm: begin
				operand_b_o = imm_i_type;
				reg_we_o = 1'b1;
				case (funct3)
					3'b000: alu_op_o = add;
					3'b010: alu_op_o = slt;
					3'b011: alu_op_o = sltu;
					3'b100: alu_op_o = xor_op;
					3'b110: alu_op_o = or_op;
					3'b111: alu_op_o = and_op;
					3'b001: begin
						alu_op_o = sll;
						operand_b_o = {27'h0, shamt};
						illegal_o = (funct7 != 7'b0000000);     // slli upper imm must be 0
					end
					default: begin      // srli / srai
						alu_op_o = inst_i[30] ? sra : srl;
						operand_b_o = {27'h0, shamt};
					end
				endcase
			end
			op_reg: begin
				reg_we_o = 1'b1;
				illegal_o = (funct7 != 7'b0000000) && (funct7 != funct7_alt);
				case (funct3)
					3'b000: alu_op_o = inst_i[30] ? sub : add;
					3'b001: alu_op_o = sll;
					3'b010: alu_op_o = slt;
					3'b011: alu_op_o = sltu;
					3'b100: alu_op_o = xor_op;
					3'b101: alu_op_o = inst_i[30] ? sra : srl;
					3'b110: alu_op_o = or_op;
					default: alu_op_o = and_op;
				endcase
			end
			lui: begin
				alu_op_o = pass_b;
				operand_b_o = imm_u_type;
				reg_we_o = 1'b1;
			end
			auipc: begin
				operand_a_o = pc_i;         // pc + (imm << 12)
				operand_b_o = imm_u_type;
				reg_we_o = 1'b1;
			end
			jal, jalr: begin
				operand_a_o = pc_i;         // link value pc + 4
				operand_b_o = pc_step;
				reg_we_o = 1'b1;
				if (opcode == jal) begin
					flow_o = jump_pc;
					imm_o = imm_j_type;
				end else begin
					flow_o = jump_reg;
					illegal_o = (funct3 != 3'b000);
				end
			end
			branch: begin
				imm_o = imm_b_type;
				case (funct3)
					3'b000: flow_o = beq;
					3'b001: flow_o = bne;
					3'b100: flow_o = blt;
					3'b101: flow_o = bge;
					3'b110: flow_o = bltu;
					3'b111: flow_o = bgeu;
					default: illegal_o = 1'b1;
				endcase
			end
			misc_mem: begin
				flow_o = seq;       // fence is a plain step
			end
			default: begin      // system, loads, stores, m ext, unknown
				illegal_o = 1'b1;
			end
		endcase
		if (illegal_o) begin
			reg_we_o = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/idex_pkg.sv ====
`default_nettype none

package idex_pkg;

	localparam int xlen = 32;           // data and pc width
	localparam int reg_addr_w = 5;      // x0..x31
	localparam int inst_w = 32;

	localparam logic [xlen-1:0] pc_step = 32'd4;        // no compressed instructions

	localparam logic [6:0] funct7_alt = 7'b0100000;     // sub / sra selector

	// major opcodes still handled by the stage
	typedef enum logic [6:0] {
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011,
		lui      = 7'b0110111,
		auipc    = 7'b0010111,
		jal      = 7'b1101111,
		jalr     = 7'b1100111,
		branch   = 7'b1100011,
		misc_mem = 7'b0001111,      // fence, pc+4 only
		system   = 7'b1110011       // always rejected
	} opcode_e;

	typedef enum logic [3:0] {
		add    = 4'd0,
		sub    = 4'd1,
		sll    = 4'd2,
		slt    = 4'd3,
		sltu   = 4'd4,
		xor_op = 4'd5,
		srl    = 4'd6,
		sra    = 4'd7,
		or_op  = 4'd8,
		and_op = 4'd9,
		pass_b = 4'd10      // lui
	} alu_op_e;

	// how the next pc is formed
	typedef enum logic [3:0] {
		seq      = 4'd0,    // pc + 4
		jump_pc  = 4'd1,    // jal
		jump_reg = 4'd2,    // jalr
		beq      = 4'd3,
		bne      = 4'd4,
		blt      = 4'd5,
		bge      = 4'd6,
		bltu     = 4'd7,
		bgeu     = 4'd8
	} flow_e;

endpackage

`default_nettype wire
